// File: list.f
source/digit_pkg.sv
source/glyph_wr_if.sv
source/decade_counter.sv
source/glyph_writer.sv
source/frame_store.sv
source/digit_display_top.sv
test/digit_display_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= digit_display_tb
FILE_LIST ?= list.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing
PASS_TEXT ?= Simulation PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILE_LIST)

# Status comes from grep, so a missing pass line fails the target
run: compile
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

// File: test/display_stimulus.txt
# name pulses colour tens ones, then tens rows 0-5 in hex
# next line holds ones rows 0-5 in hex
after_reset 0 0 0 0 00000000 00000000 00000000 00000000 00000000 00000000
    00000000 00000000 00000000 00000000 00000000 00000000
one_step 1 1 0 1 00000000 00000000 00000000 00000000 00000000 00000000
    00000000 10000010 11111111 10000000 00000000 00000000
carry_to_ten 9 2 1 0 00000000 20000020 22222222 20000000 00000000 00000000
    02222220 20000002 20000002 20000002 02222220 00000000
colour_change 1 5 1 1 00000000 20000020 22222222 20000000 00000000 00000000
    00000000 50000050 55555555 50000000 00000000 00000000
back_to_back 3 3 1 4 00000000 20000020 22222222 20000000 00000000 00000000
    00003333 00003000 00003000 00003000 33333333 00000000
wrap_to_zero 86 6 0 0 06666660 60000006 60000006 60000006 06666660 00000000
    06666660 60000006 60000006 60000006 06666660 00000000
final_seven 7 7 0 7 06666660 60000006 60000006 60000006 06666660 00000000
    00000007 77000007 00770007 00007707 00000077 00000000

// File: test/digit_display_tb.sv
`timescale 1ns/1ps
`default_nettype none

module digit_display_tb;

    localparam int ADDR_W    = 10;
    localparam int ONES_BASE = 94;
    localparam int TENS_BASE = 86;
    localparam int MAX_STEPS = 32;
    localparam int NAME_W    = 8 * 24;

    logic                clk;
    logic                rst;
    logic                next;
    digit_pkg::color_t   color;
    logic [ADDR_W-1:0]   rd_addr;
    digit_pkg::fb_word_t rd_data;
    logic                busy;
    digit_pkg::digit_t   ones;
    digit_pkg::digit_t   tens;

    logic [NAME_W-1:0]   step_name [MAX_STEPS];
    int                  step_pulses [MAX_STEPS];
    int                  step_color [MAX_STEPS];
    int                  step_tens [MAX_STEPS];
    int                  step_ones [MAX_STEPS];
    // Tens rows 0 to 5, then ones rows 0 to 5
    digit_pkg::fb_word_t exp_words [MAX_STEPS][12];
    int                  num_steps;
    logic                steps_loaded;

    digit_display_top digit_display_top_i (
        .clk     (clk),
        .rst     (rst),
        .next    (next),
        .color   (color),
        .rd_addr (rd_addr),
        .rd_data (rd_data),
        .busy    (busy),
        .ones    (ones),
        .tens    (tens)
    );

    initial
    begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    ////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////

    task automatic check_word(input logic [NAME_W-1:0] name, input string what,
                              input digit_pkg::fb_word_t expected,
                              input digit_pkg::fb_word_t actual);
        if (actual !== expected)
        begin
            $display("ERR %0s %s: expected %h, actual %h", name, what, expected, actual);
            $display("Simulation FAILED");
            $fatal(1);
        end
    endtask

    task automatic check_digit(input logic [NAME_W-1:0] name, input string what,
                               input digit_pkg::digit_t expected,
                               input digit_pkg::digit_t actual);
        if (actual !== expected)
        begin
            $display("ERR %0s %s: expected %0d, actual %0d", name, what, expected, actual);
            $display("Simulation FAILED");
            $fatal(1);
        end
    endtask

    task automatic check_level(input logic [NAME_W-1:0] name, input string what,
                               input logic expected, input logic actual);
        if (actual !== expected)
        begin
            $display("ERR %0s %s: expected %b, actual %b", name, what, expected, actual);
            $display("Simulation FAILED");
            $fatal(1);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////

    // Land just after the edge, where outputs have settled
    task automatic tick();
        @(posedge clk);
        #2;
    endtask

    task automatic load_steps();
        int                fd;
        int                code;
        logic [NAME_W-1:0] tok;
        logic [8*128-1:0]  rest;
        fd = $fopen("test/display_stimulus.txt", "r");
        if (fd == 0)
        begin
            $display("Could not open the stimulus file");
            $display("Simulation FAILED");
            $fatal(1);
        end
        num_steps = 0;
        while ($fscanf(fd, "%s", tok) == 1 && num_steps < MAX_STEPS)
        begin
            // A lone # token starts a comment line
            if (tok[7:0] == 8'h23 && tok[NAME_W-1:8] == '0)
            begin
                void'($fgets(rest, fd));
            end
            else
            begin
                step_name[num_steps] = tok;
                code = $fscanf(fd, "%d %d %d %d", step_pulses[num_steps],
                               step_color[num_steps], step_tens[num_steps],
                               step_ones[num_steps]);
                for (int w = 0; w < 12; w++)
                begin
                    code += $fscanf(fd, "%h", exp_words[num_steps][w]);
                end
                if (code != 16)
                begin
                    $display("Stimulus step %0d is incomplete", num_steps + 1);
                    $display("Simulation FAILED");
                    $fatal(1);
                end
                num_steps++;
            end
        end
        $fclose(fd);
        if (num_steps == 0)
        begin
            $display("The stimulus file holds no steps");
            $display("Simulation FAILED");
            $fatal(1);
        end
    endtask

    task automatic run_step(input int s);
        string what;
        repeat ($urandom_range(1, 4)) tick();
        color = digit_pkg::color_t'(step_color[s]);
        for (int p = 0; p < step_pulses[s]; p++)
        begin
            next = 1'b1;
            tick();
            next = 1'b0;
            tick();
        end
        // A redraw is under way one cycle after the last pulse
        check_level(step_name[s], "busy", step_pulses[s] != 0, busy);
        while (busy)
        begin
            tick();
        end
        check_digit(step_name[s], "tens", digit_pkg::digit_t'(step_tens[s]), tens);
        check_digit(step_name[s], "ones", digit_pkg::digit_t'(step_ones[s]), ones);
        for (int w = 0; w < 12; w++)
        begin
            rd_addr = (w < 6) ? ADDR_W'(TENS_BASE + w) : ADDR_W'(ONES_BASE + w - 6);
            tick();
            what = $sformatf("%s row %0d", (w < 6) ? "tens" : "ones", w % 6);
            check_word(step_name[s], what, exp_words[s][w], rd_data);
        end
    endtask

    initial
    begin
        rst          = 1'b1;
        next         = 1'b0;
        color        = '0;
        rd_addr      = '0;
        steps_loaded = 1'b0;
        void'($urandom(32'h18c4c6b0));
        load_steps();
        steps_loaded = 1'b1;
        repeat (10) @(posedge clk);
        #2;
        rst = 1'b0;
        for (int s = 0; s < num_steps; s++)
        begin
            run_step(s);
        end
        $display("Simulation PASSED");
        $finish;
    end

    // Budget of 2000 cycles per step, plus one for reset
    initial
    begin
        wait (steps_loaded === 1'b1);
        repeat ((num_steps + 1) * 2000) @(posedge clk);
        $display("Watchdog expired before all steps finished");
        $display("Simulation FAILED");
        $fatal(1);
    end

endmodule

`default_nettype wire

// File: source/digit_display_top.sv
`timescale 1ns/1ps
`default_nettype none

module digit_display_top #(
    parameter int ADDR_W    = 10,
    parameter int ONES_BASE = 94,
    parameter int TENS_BASE = 86
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                next,
    input  digit_pkg::color_t   color,
    input  logic [ADDR_W-1:0]   rd_addr,
    output digit_pkg::fb_word_t rd_data,
    output logic                busy,
    output digit_pkg::digit_t   ones,
    output digit_pkg::digit_t   tens
);

    logic ones_changed;
    logic tens_changed;

    glyph_wr_if #(.ADDR_W(ADDR_W)) ones_wr ();
    glyph_wr_if #(.ADDR_W(ADDR_W)) tens_wr ();

    decade_counter counter (
        .clk          (clk),
        .rst          (rst),
        .next         (next),
        .ones         (ones),
        .tens         (tens),
        .ones_changed (ones_changed),
        .tens_changed (tens_changed)
    );

    // Each writer redraws only when its own digit changes
    glyph_writer #(.ADDR_W(ADDR_W), .BASE(ONES_BASE)) ones_writer (
        .clk   (clk),
        .rst   (rst),
        .start (ones_changed),
        .digit (ones),
        .color (color),
        .wr    (ones_wr.writer)
    );

    glyph_writer #(.ADDR_W(ADDR_W), .BASE(TENS_BASE)) tens_writer (
        .clk   (clk),
        .rst   (rst),
        .start (tens_changed),
        .digit (tens),
        .color (color),
        .wr    (tens_wr.writer)
    );

    frame_store #(.ADDR_W(ADDR_W)) store (
        .clk     (clk),
        .ones_wr (ones_wr.store),
        .tens_wr (tens_wr.store),
        .rd_addr (rd_addr),
        .rd_data (rd_data),
        .busy    (busy)
    );

endmodule

`default_nettype wire

// File: source/frame_store.sv
`timescale 1ns/1ps
`default_nettype none

module frame_store #(
    parameter int ADDR_W = 10
) (
    input  logic                clk,
    glyph_wr_if.store           ones_wr,
    glyph_wr_if.store           tens_wr,
    input  logic [ADDR_W-1:0]   rd_addr,
    output digit_pkg::fb_word_t rd_data,
    output logic                busy
);

    localparam int DEPTH = 2 ** ADDR_W;

    digit_pkg::fb_word_t mem [DEPTH];

    // Blank screen from power-up
    initial
    begin
        for (int i = 0; i < DEPTH; i++)
        begin
            mem[i] = '0;
        end
    end

    ////////////////////////////////////////////////////////////
    // Write ports
    ////////////////////////////////////////////////////////////

    // Glyph areas never overlap, so both writes land in one cycle
    always_ff @(posedge clk)
    begin
        if (tens_wr.wr_en)
        begin
            mem[tens_wr.wr_addr] <= tens_wr.wr_data;
        end
        if (ones_wr.wr_en)
        begin
            mem[ones_wr.wr_addr] <= ones_wr.wr_data;
        end
    end

    ////////////////////////////////////////////////////////////
    // Read port
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        rd_data <= mem[rd_addr];
    end

    assign busy = ones_wr.busy | tens_wr.busy;

endmodule

`default_nettype wire

// File: source/glyph_writer.sv
`timescale 1ns/1ps
`default_nettype none

module glyph_writer #(
    parameter int ADDR_W = 10,
    parameter int BASE   = 94
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              start,
    input  digit_pkg::digit_t digit,
    input  digit_pkg::color_t color,
    glyph_wr_if.writer        wr
);

    ////////////////////////////////////////////////////////////
    // Glyph bitmaps
    ////////////////////////////////////////////////////////////

    // Bit 7 is the leftmost pixel of a row
    localparam logic [7:0] GLYPH_BITS [10][5] = '{
        '{8'h7E, 8'h81, 8'h81, 8'h81, 8'h7E},
        '{8'h00, 8'h82, 8'hFF, 8'h80, 8'h00},
        '{8'hC2, 8'hA1, 8'h91, 8'h89, 8'h86},
        '{8'h42, 8'h81, 8'h89, 8'h89, 8'h76},
        '{8'h0F, 8'h08, 8'h08, 8'h08, 8'hFF},
        '{8'h4F, 8'h89, 8'h89, 8'h89, 8'h71},
        '{8'h78, 8'h8C, 8'h8A, 8'h89, 8'h70},
        '{8'h01, 8'hC1, 8'h31, 8'h0D, 8'h03},
        '{8'h6E, 8'h91, 8'h91, 8'h91, 8'h6E},
        '{8'h06, 8'h09, 8'h09, 8'h09, 8'hFE}
    };

    localparam digit_pkg::glyph_row_t LAST_ROW =
        digit_pkg::glyph_row_t'(digit_pkg::GLYPH_ROWS - 1);

    digit_pkg::writer_state_t state;
    digit_pkg::glyph_row_t    row;
    digit_pkg::digit_t        digit_q;
    digit_pkg::color_t        color_q;
    logic [7:0]               row_bits;
    digit_pkg::pixel_t        lit_pixel;

    ////////////////////////////////////////////////////////////
    // Row sequencer
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state <= digit_pkg::writer_idle;
            row   <= '0;
        end
        else if (start)
        begin
            // A new request restarts the glyph from the top
            state <= digit_pkg::writer_draw;
            row   <= '0;
        end
        else if (state == digit_pkg::writer_draw)
        begin
            if (row == LAST_ROW)
            begin
                state <= digit_pkg::writer_idle;
                row   <= '0;
            end
            else
            begin
                row <= row + 3'd1;
            end
        end
    end

    // Digit and colour held for the whole redraw
    always_ff @(posedge clk)
    begin
        if (start)
        begin
            digit_q <= digit;
            color_q <= color;
        end
    end

    ////////////////////////////////////////////////////////////
    // Row data
    ////////////////////////////////////////////////////////////

    always_comb
    begin
        row_bits = '0;
        if (row != LAST_ROW)
        begin
            row_bits = GLYPH_BITS[digit_q][row];
        end
    end

    assign lit_pixel = {1'b0, color_q};

    always_comb
    begin
        for (int i = 0; i < 8; i++)
        begin
            wr.wr_data[4*i +: 4] = row_bits[i] ? lit_pixel : 4'h0;
        end
    end

    assign wr.wr_en   = (state == digit_pkg::writer_draw);
    assign wr.busy    = (state == digit_pkg::writer_draw);
    assign wr.wr_addr = ADDR_W'(BASE) + ADDR_W'(row);

endmodule

`default_nettype wire

// File: source/decade_counter.sv
`timescale 1ns/1ps
`default_nettype none

module decade_counter (
    input  logic              clk,
    input  logic              rst,
    input  logic              next,
    output digit_pkg::digit_t ones,
    output digit_pkg::digit_t tens,
    output logic              ones_changed,
    output logic              tens_changed
);

    localparam digit_pkg::digit_t DIGIT_MAX = 4'd9;

    logic carry;

    // Ones digit rolls over on this step
    assign carry = next && (ones == DIGIT_MAX);

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            ones         <= '0;
            tens         <= '0;
            ones_changed <= 1'b0;
            tens_changed <= 1'b0;
        end
        else
        begin
            ones_changed <= next;
            tens_changed <= carry;

            if (carry)
            begin
                ones <= '0;
                // 99 wraps to 00
                if (tens == DIGIT_MAX)
                begin
                    tens <= '0;
                end
                else
                begin
                    tens <= tens + 4'd1;
                end
            end
            else if (next)
            begin
                ones <= ones + 4'd1;
            end
        end
    end

endmodule

`default_nettype wire

// File: source/glyph_wr_if.sv
`timescale 1ns/1ps
`default_nettype none

// One glyph writer's write stream into the frame store
interface glyph_wr_if #(
    parameter int ADDR_W = 10
) ();

    logic                  wr_en;
    logic [ADDR_W-1:0]     wr_addr;
    digit_pkg::fb_word_t   wr_data;
    logic                  busy;

    modport writer (
        output wr_en,
        output wr_addr,
        output wr_data,
        output busy
    );

    modport store (
        input wr_en,
        input wr_addr,
        input wr_data,
        input busy
    );

endinterface

`default_nettype wire

// File: source/digit_pkg.sv
`default_nettype none

package digit_pkg;

    ////////////////////////////////////////////////////////////
    // Frame buffer data
    ////////////////////////////////////////////////////////////

    // Zero top bit above the 3-bit colour
    typedef logic [3:0] pixel_t;

    typedef logic [2:0] color_t;

    // Eight pixels, leftmost pixel in the highest nibble
    typedef logic [31:0] fb_word_t;

    ////////////////////////////////////////////////////////////
    // Glyph drawing
    ////////////////////////////////////////////////////////////

    // Decimal digit, 0 to 9
    typedef logic [3:0] digit_t;

    // Row index, row 5 is the blank spacer
    typedef logic [2:0] glyph_row_t;

    typedef enum logic {
        writer_idle,
        writer_draw
    } writer_state_t;

    localparam int GLYPH_ROWS = 6;

endpackage

`default_nettype wire
